//--- sp_pkg.sv
/*
  shared widths and sample reset code for the analog path
  system bus address map and housekeeping register offsets
  address word union, raw or region/offset view
  sample code flip between two's complement and negative slope
*/

package sp_pkg;

  // --------------------
  // datapath widths
  localparam int ADC_W = 14;  // adc and dac sample
  localparam int SUM_W = 15;  // asg + pid before saturation
  localparam int RB_W  = 16;  // override sample, top ADC_W bits used
  localparam int LED_W = 8;

  // code that means zero on the pins (negative slope)
  localparam logic [ADC_W-1:0] ZERO_CODE = 14'h1FFF;

  // --------------------
  // system bus map
  localparam int BUS_W      = 32;
  localparam int REGION_N   = 8;                     // 1 MiB each
  localparam int REGION_LSB = 20;
  localparam int REGION_W   = $clog2(REGION_N);
  localparam int RSV_W      = BUS_W - REGION_W - REGION_LSB;  // bits 31..23

  localparam logic [REGION_W-1:0] HK_REGION = 3'd0;

  // housekeeping offsets, inside region 0
  localparam logic [REGION_LSB-1:0] HK_ID_OFS   = 20'h0_0000;
  localparam logic [REGION_LSB-1:0] HK_LOOP_OFS = 20'h0_000C;
  localparam logic [REGION_LSB-1:0] HK_LED_OFS  = 20'h0_0030;

  localparam logic [BUS_W-1:0] HK_ID = 32'h5250_0001;  // read only id word

  // address word, seen raw or split into fields
  typedef struct packed {
    logic [RSV_W-1:0]      rsv;     // ignored
    logic [REGION_W-1:0]   region;  // picks the slave
    logic [REGION_LSB-1:0] offset;  // register inside the slave
  } sys_addr_s;

  typedef union packed {
    logic [BUS_W-1:0] raw;
    sys_addr_s        f;
  } sys_addr_u;

  // keep sign, invert the rest; works in both directions
  function automatic logic [ADC_W-1:0] flip_code(input logic [ADC_W-1:0] s);
    return {s[ADC_W-1], ~s[ADC_W-2:0]};
  endfunction

endpackage

//--- sys_bus_if.sv
/*
  system bus between the region decoder and one slave
  strobes are single-cycle, slave acks one cycle later
*/

`timescale 1ns/1ps

interface sys_bus_if;
  import sp_pkg::*;

  sys_addr_u        addr;   // held by master until ack
  logic [BUS_W-1:0] wdata;  // full word writes only
  logic             wen;    // write strobe
  logic             ren;    // read strobe
  logic [BUS_W-1:0] rdata;  // valid with ack
  logic             ack;
  logic             err;

  // decoder side
  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  // register block side
  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

//--- adc_front.sv
/*
  adc input registers for both channels
  negative slope offset code to two's complement
  digital loopback select in front of the outputs
*/

`timescale 1ns/1ps

module adc_front (
  input  logic                           adc_clk,
  input  logic                           rst_i,
  input  logic        [sp_pkg::ADC_W-1:0] adc_dat_a_i,  // raw pins, ch a
  input  logic        [sp_pkg::ADC_W-1:0] adc_dat_b_i,  // raw pins, ch b
  input  logic                           loop_i,       // hk loopback bit
  input  logic signed [sp_pkg::ADC_W-1:0] loop_a_i,     // mix, ch a
  input  logic signed [sp_pkg::ADC_W-1:0] loop_b_i,     // mix, ch b
  output logic signed [sp_pkg::ADC_W-1:0] adc_a_o,
  output logic signed [sp_pkg::ADC_W-1:0] adc_b_o
);
  import sp_pkg::*;

  logic [ADC_W-1:0] dat_a_q;  // io register
  logic [ADC_W-1:0] dat_b_q;

  // cleared to the code of zero, so the samples read 0
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dat_a_q <= ZERO_CODE;
      dat_b_q <= ZERO_CODE;
    end else begin
      dat_a_q <= adc_dat_a_i;
      dat_b_q <= adc_dat_b_i;
    end
  end

  // --------------------
  // loopback takes the mix register directly, no extra stage
  always_comb begin
    if (loop_i) begin
      adc_a_o = loop_a_i;
      adc_b_o = loop_b_i;
    end else begin
      adc_a_o = flip_code(dat_a_q);  // to two's complement
      adc_b_o = flip_code(dat_b_q);
    end
  end

endmodule

//--- dac_mix.sv
/*
  per channel sum of generator and controller samples
  clamp to 14 bits on overflow, one register stage
*/

`timescale 1ns/1ps

module dac_mix (
  input  logic                           adc_clk,
  input  logic                           rst_i,
  input  logic signed [sp_pkg::ADC_W-1:0] asg_a_i,  // generator
  input  logic signed [sp_pkg::ADC_W-1:0] asg_b_i,
  input  logic signed [sp_pkg::ADC_W-1:0] pid_a_i,  // controller
  input  logic signed [sp_pkg::ADC_W-1:0] pid_b_i,
  output logic signed [sp_pkg::ADC_W-1:0] mix_a_o,
  output logic signed [sp_pkg::ADC_W-1:0] mix_b_o
);
  import sp_pkg::*;

  logic signed [SUM_W-1:0] sum_a;  // one guard bit
  logic signed [SUM_W-1:0] sum_b;
  logic signed [ADC_W-1:0] sat_a;
  logic signed [ADC_W-1:0] sat_b;

  // top two bits differ -> out of 14-bit range
  function automatic logic signed [ADC_W-1:0] saturate(
    input logic signed [SUM_W-1:0] s
  );
    logic neg;
    neg = s[SUM_W-1];
    if (s[SUM_W-1] ^ s[SUM_W-2])
      return {neg, {(ADC_W-1){~neg}}};  // 0x1fff or 0x2000
    else
      return s[ADC_W-1:0];
  endfunction

  // --------------------
  // both operands signed, so sign extended to SUM_W
  assign sum_a = asg_a_i + pid_a_i;
  assign sum_b = asg_b_i + pid_b_i;

  assign sat_a = saturate(sum_a);
  assign sat_b = saturate(sum_b);

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      mix_a_o <= '0;
      mix_b_o <= '0;
    end else begin
      mix_a_o <= sat_a;  // also feeds the loopback
      mix_b_o <= sat_b;
    end
  end

endmodule

//--- dac_front.sv
/*
  override select between mix and the external samples
  negative slope dac coding and output registers
  registered reset strobe for the dac
*/

`timescale 1ns/1ps

module dac_front (
  input  logic                           adc_clk,
  input  logic                           rst_i,
  input  logic signed [sp_pkg::ADC_W-1:0] mix_a_i,
  input  logic signed [sp_pkg::ADC_W-1:0] mix_b_i,
  input  logic                           rb_active_i,  // override takes the dac
  input  logic signed [sp_pkg::RB_W-1:0]  rb_a_i,
  input  logic signed [sp_pkg::RB_W-1:0]  rb_b_i,
  output logic        [sp_pkg::ADC_W-1:0] dac_dat_a_o,
  output logic        [sp_pkg::ADC_W-1:0] dac_dat_b_o,
  output logic                           dac_rst_o
);
  import sp_pkg::*;

  logic signed [ADC_W-1:0] sel_a;
  logic signed [ADC_W-1:0] sel_b;

  // override drops the low RB_W-ADC_W bits
  always_comb begin
    if (rb_active_i) begin
      sel_a = rb_a_i[RB_W-1 -: ADC_W];
      sel_b = rb_b_i[RB_W-1 -: ADC_W];
    end else begin
      sel_a = mix_a_i;
      sel_b = mix_b_i;
    end
  end

  // --------------------
  // output registers, idle at the code of zero
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_dat_a_o <= ZERO_CODE;
      dac_dat_b_o <= ZERO_CODE;
    end else begin
      dac_dat_a_o <= flip_code(sel_a);  // two's complement -> neg slope
      dac_dat_b_o <= flip_code(sel_b);
    end
  end

  // high through reset, then one more cycle
  always_ff @(posedge adc_clk) begin
    dac_rst_o <= rst_i;
  end

endmodule

//--- sys_bus_decode.sv
/*
  system bus region decoder, 8 regions of 1 MiB
  strobes go to the housekeeping slave only
  unused regions answer at once with zero data
*/

`timescale 1ns/1ps

module sys_bus_decode (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  input  logic [sp_pkg::BUS_W-1:0] sys_addr_i,
  input  logic [sp_pkg::BUS_W-1:0] sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [sp_pkg::BUS_W-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  sys_bus_if.master                hk             // region 0 slave
);
  import sp_pkg::*;

  sys_addr_u addr;
  logic      hk_sel;   // address falls in region 0
  logic      strobe;   // any access this cycle
  logic      hk_pend;  // region 0 access waiting for ack

  assign addr   = sys_addr_i;
  assign hk_sel = (addr.f.region == HK_REGION);
  assign strobe = sys_wen_i | sys_ren_i;

  // --------------------
  // towards the slave
  assign hk.addr  = addr;
  assign hk.wdata = sys_wdata_i;
  assign hk.wen   = sys_wen_i & hk_sel;
  assign hk.ren   = sys_ren_i & hk_sel;

  // remembers that next cycle belongs to the slave
  always_ff @(posedge adc_clk) begin
    if (rst_i)
      hk_pend <= 1'b0;
    else
      hk_pend <= hk.wen | hk.ren;
  end

  // --------------------
  // response return
  always_comb begin
    if (hk_pend) begin
      sys_rdata_o = hk.rdata;  // valid with ack
      sys_ack_o   = hk.ack;
      sys_err_o   = hk.err;
    end else begin
      // unused slaves: same-cycle ack, no data, no error
      sys_rdata_o = '0;
      sys_ack_o   = strobe & ~hk_sel;
      sys_err_o   = 1'b0;
    end
  end

endmodule

//--- hk_regs.sv
/*
  housekeeping register block on region 0
  id word, loopback bit and led register
  led output multiplexer with external override
*/

`timescale 1ns/1ps

module hk_regs (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  sys_bus_if.slave                 bus,
  input  logic                     rb_leds_en_i,  // override owns the leds
  input  logic [sp_pkg::LED_W-1:0] rb_leds_i,
  output logic                     loop_o,        // digital loopback
  output logic [sp_pkg::LED_W-1:0] led_o
);
  import sp_pkg::*;

  logic [REGION_LSB-1:0] ofs;
  logic                  loop_q;
  logic [LED_W-1:0]      led_q;
  logic [BUS_W-1:0]      rdata_q;
  logic                  ack_q;

  assign ofs = bus.addr.f.offset;  // region already checked by decoder

  // --------------------
  // write side, unknown offsets dropped
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      loop_q <= 1'b0;
      led_q  <= '0;
    end else if (bus.wen) begin
      case (ofs)
        HK_LOOP_OFS: loop_q <= bus.wdata[0];
        HK_LED_OFS:  led_q  <= bus.wdata[LED_W-1:0];
        default:     ;  // id is read only
      endcase
    end
  end

  // --------------------
  // read side, one cycle latency
  always_ff @(posedge adc_clk) begin
    if (bus.ren) begin
      case (ofs)
        HK_ID_OFS:   rdata_q <= HK_ID;
        HK_LOOP_OFS: rdata_q <= BUS_W'(loop_q);
        HK_LED_OFS:  rdata_q <= BUS_W'(led_q);
        default:     rdata_q <= '0;
      endcase
    end
  end

  // ack for reads and writes alike
  always_ff @(posedge adc_clk) begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= bus.wen | bus.ren;
  end

  assign bus.rdata = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;  // every offset answers

  assign loop_o = loop_q;
  assign led_o  = rb_leds_en_i ? rb_leds_i : led_q;

endmodule

//--- analog_top.sv
/*
  analog signal path top level, single adc_clk domain
  adc capture, dac mixing and dac output stages
  system bus decoder and housekeeping registers
*/

`timescale 1ns/1ps

module analog_top (
  input  logic                           adc_clk,
  input  logic                           rst_i,
  // adc pins
  input  logic        [sp_pkg::ADC_W-1:0] adc_dat_a_i,
  input  logic        [sp_pkg::ADC_W-1:0] adc_dat_b_i,
  output logic signed [sp_pkg::ADC_W-1:0] adc_a_o,      // to scope/pid side
  output logic signed [sp_pkg::ADC_W-1:0] adc_b_o,
  // sample sources
  input  logic signed [sp_pkg::ADC_W-1:0] asg_a_i,
  input  logic signed [sp_pkg::ADC_W-1:0] asg_b_i,
  input  logic signed [sp_pkg::ADC_W-1:0] pid_a_i,
  input  logic signed [sp_pkg::ADC_W-1:0] pid_b_i,
  // override source
  input  logic                           rb_active_i,
  input  logic signed [sp_pkg::RB_W-1:0]  rb_a_i,
  input  logic signed [sp_pkg::RB_W-1:0]  rb_b_i,
  input  logic                           rb_leds_en_i,
  input  logic        [sp_pkg::LED_W-1:0] rb_leds_i,
  // dac pins, parallel per channel
  output logic        [sp_pkg::ADC_W-1:0] dac_dat_a_o,
  output logic        [sp_pkg::ADC_W-1:0] dac_dat_b_o,
  output logic                           dac_rst_o,
  output logic        [sp_pkg::LED_W-1:0] led_o,
  // system bus
  input  logic        [sp_pkg::BUS_W-1:0] sys_addr_i,
  input  logic        [sp_pkg::BUS_W-1:0] sys_wdata_i,
  input  logic                           sys_wen_i,
  input  logic                           sys_ren_i,
  output logic        [sp_pkg::BUS_W-1:0] sys_rdata_o,
  output logic                           sys_ack_o,
  output logic                           sys_err_o
);
  import sp_pkg::*;

  logic signed [ADC_W-1:0] mix_a;  // saturated sum, also loopback source
  logic signed [ADC_W-1:0] mix_b;
  logic                    loop;   // from hk

  sys_bus_if bus_hk ();

  // --------------------
  // analog path
  adc_front i_adc (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_i      (loop),
    .loop_a_i    (mix_a),
    .loop_b_i    (mix_b),
    .adc_a_o     (adc_a_o),
    .adc_b_o     (adc_b_o)
  );

  dac_mix i_mix (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .asg_a_i (asg_a_i),
    .asg_b_i (asg_b_i),
    .pid_a_i (pid_a_i),
    .pid_b_i (pid_b_i),
    .mix_a_o (mix_a),
    .mix_b_o (mix_b)
  );

  dac_front i_dac (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .mix_a_i     (mix_a),
    .mix_b_i     (mix_b),
    .rb_active_i (rb_active_i),
    .rb_a_i      (rb_a_i),
    .rb_b_i      (rb_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_rst_o   (dac_rst_o)
  );

  // --------------------
  // register access
  sys_bus_decode i_dec (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .hk          (bus_hk.master)
  );

  hk_regs i_hk (
    .adc_clk      (adc_clk),
    .rst_i        (rst_i),
    .bus          (bus_hk.slave),
    .rb_leds_en_i (rb_leds_en_i),
    .rb_leds_i    (rb_leds_i),
    .loop_o       (loop),
    .led_o        (led_o)
  );

endmodule

//--- tb_analog_top.sv
/*
  testbench for the analog path top level
  clock, reset, galois lfsr, typed compare tasks
  directed tests for adc, mix, override, registers, loopback
*/

`timescale 1ns/1ps

module tb_analog_top;
  import sp_pkg::*;

  localparam int          HALF_PER  = 20;            // 40 ns clock
  localparam int          ACK_TMO   = 8;             // cycles
  localparam logic [31:0] LFSR_MASK = 32'h8020_0003; // x^32+x^22+x^2+x+1

  logic                    adc_clk;
  logic                    rst_i;
  logic        [ADC_W-1:0] adc_dat_a_i, adc_dat_b_i;
  logic signed [ADC_W-1:0] adc_a_o, adc_b_o;
  logic signed [ADC_W-1:0] asg_a_i, asg_b_i, pid_a_i, pid_b_i;
  logic                    rb_active_i;
  logic signed [RB_W-1:0]  rb_a_i, rb_b_i;
  logic                    rb_leds_en_i;
  logic        [LED_W-1:0] rb_leds_i, led_o;
  logic        [ADC_W-1:0] dac_dat_a_o, dac_dat_b_o;
  logic                    dac_rst_o;
  logic        [BUS_W-1:0] sys_addr_i, sys_wdata_i, sys_rdata_o;
  logic                    sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;
  logic [31:0]             lfsr_q;

  analog_top i_dut (.*);

  always #HALF_PER adc_clk = ~adc_clk;

  // --------------------
  // random source, one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_MASK) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  // reference models
  function automatic int clamp_sum(input logic signed [ADC_W-1:0] a,
                                   input logic signed [ADC_W-1:0] b);
    int s;
    s = int'(a) + int'(b);
    if (s > 8191) s = 8191;
    if (s < -8192) s = -8192;
    return s;
  endfunction

  function automatic logic [ADC_W-1:0] dac_code(input int v);
    return ADC_W'(8191 - v);  // zero sits at 0x1fff, slope down
  endfunction

  function automatic logic [ADC_W-1:0] adc_value(input logic [ADC_W-1:0] raw);
    return ADC_W'(8191 - int'(raw));
  endfunction

  // --------------------
  // failure and compare tasks
  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_sample(input string test, input logic [ADC_W-1:0] exp,
                              input logic [ADC_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", test, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string test, input logic [BUS_W-1:0] exp,
                            input logic [BUS_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", test, exp, act);
      abort_run();
    end
  endtask

  task automatic check_leds(input string test, input logic [LED_W-1:0] exp,
                            input logic [LED_W-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", test, exp, act);
      abort_run();
    end
  endtask

  // one bus access, sampled mid low phase
  task automatic bus_xfer(input string test, input logic [BUS_W-1:0] addr, input logic wr,
                          input logic [BUS_W-1:0] wdata, input int exp_lat,
                          output logic [BUS_W-1:0] rdata);
    int waited;
    @(negedge adc_clk);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = ~wr;
    waited      = 0;
    #5;
    while (sys_ack_o !== 1'b1) begin
      if (waited == ACK_TMO) begin
        $display("%s: no ack on the bus within %0d cycles", test, ACK_TMO);
        abort_run();
      end else begin
        @(negedge adc_clk);
        sys_wen_i = 1'b0;  // strobe is one cycle
        sys_ren_i = 1'b0;
        #5;
        waited++;
      end
    end
    rdata = sys_rdata_o;
    if (waited != exp_lat) begin
      $display("ERROR %s: expected ack latency %0d, actual %0d", test, exp_lat, waited);
      abort_run();
    end
    if (sys_err_o !== 1'b0) begin
      $display("%s: bus returned an error", test);
      abort_run();
    end
    if (sys_wen_i || sys_ren_i) begin  // same-cycle ack
      @(negedge adc_clk);
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
    end
  endtask

  task automatic bus_write(input string test, input logic [BUS_W-1:0] addr,
                           input logic [BUS_W-1:0] data, input int lat);
    logic [BUS_W-1:0] unused;
    bus_xfer(test, addr, 1'b1, data, lat, unused);
  endtask

  task automatic bus_read(input string test, input logic [BUS_W-1:0] addr, input int lat,
                          output logic [BUS_W-1:0] data);
    bus_xfer(test, addr, 1'b0, '0, lat, data);
  endtask

  // --------------------
  // directed tests
  task automatic reset_state();
    logic [BUS_W-1:0] rd;
    @(negedge adc_clk);
    check_sample("reset dac a", 14'h1FFF, dac_dat_a_o);
    check_sample("reset dac b", 14'h1FFF, dac_dat_b_o);
    check_leds("reset leds", 8'h00, led_o);
    if (sys_ack_o !== 1'b0 || dac_rst_o !== 1'b0) begin
      $display("ack or dac reset still high after reset");
      abort_run();
    end
    bus_read("reset loop reg", 32'h0000_000C, 1, rd);
    check_word("reset loop reg", 32'h0, rd);
  endtask

  task automatic adc_conversion();
    logic [ADC_W-1:0] raw_a, raw_b;
    for (int n = 0; n < 32; n++) begin
      @(negedge adc_clk);
      raw_a = (n == 0) ? 14'h0000 : (n == 1) ? 14'h3FFF : ADC_W'(rand_bits(ADC_W));
      raw_b = (n == 0) ? 14'h2000 : (n == 1) ? 14'h1FFF : ADC_W'(rand_bits(ADC_W));
      adc_dat_a_i = raw_a;
      adc_dat_b_i = raw_b;
      @(negedge adc_clk);  // one register stage
      check_sample("adc conv a", adc_value(raw_a), adc_a_o);
      check_sample("adc conv b", adc_value(raw_b), adc_b_o);
    end
  endtask

  task automatic apply_mix(input string test,
                           input logic signed [ADC_W-1:0] aa, input logic signed [ADC_W-1:0] pa,
                           input logic signed [ADC_W-1:0] ab, input logic signed [ADC_W-1:0] pb);
    @(negedge adc_clk);
    asg_a_i = aa;
    pid_a_i = pa;
    asg_b_i = ab;
    pid_b_i = pb;
    repeat (2) @(negedge adc_clk);  // mix + dac register
    check_sample(test, dac_code(clamp_sum(aa, pa)), dac_dat_a_o);
    check_sample(test, dac_code(clamp_sum(ab, pb)), dac_dat_b_o);
  endtask

  task automatic mix_saturation();
    apply_mix("mix pos ovf", 14'h1FFF, 14'h1FFF, 14'h2000, 14'h2000);
    apply_mix("mix mixed sign", 14'h1FFF, 14'h2000, 14'h0001, 14'h3FFF);
    apply_mix("mix near limit", 14'd5000, 14'd4000, -14'sd5000, -14'sd4000);
    for (int n = 0; n < 24; n++)
      apply_mix("mix random", ADC_W'(rand_bits(ADC_W)), ADC_W'(rand_bits(ADC_W)),
                ADC_W'(rand_bits(ADC_W)), ADC_W'(rand_bits(ADC_W)));
  endtask

  task automatic override_select();
    logic [RB_W-1:0] ra, rb;
    for (int n = 0; n < 16; n++) begin
      @(negedge adc_clk);
      ra = RB_W'(rand_bits(RB_W));
      rb = RB_W'(rand_bits(RB_W));
      rb_active_i = 1'b1;
      rb_a_i      = ra;
      rb_b_i      = rb;
      @(negedge adc_clk);
      check_sample("override a", dac_code(int'($signed(ra[15:2]))), dac_dat_a_o);
      check_sample("override b", dac_code(int'($signed(rb[15:2]))), dac_dat_b_o);
    end
    rb_active_i = 1'b0;
  endtask

  task automatic register_access();
    logic [BUS_W-1:0] rd;
    logic [LED_W-1:0] ext;
    bus_read("id read", 32'h0000_0000, 1, rd);
    check_word("id read", 32'h5250_0001, rd);
    bus_write("led write", 32'h0000_0030, 32'hFFFF_FF5A, 1);
    bus_read("led read", 32'h0000_0030, 1, rd);
    check_word("led read", 32'h0000_005A, rd);  // only low byte kept
    check_leds("led pins", 8'h5A, led_o);
    @(negedge adc_clk);
    ext          = LED_W'(rand_bits(LED_W));
    rb_leds_en_i = 1'b1;
    rb_leds_i    = ext;
    @(negedge adc_clk);
    check_leds("led override", ext, led_o);
    rb_leds_en_i = 1'b0;
    @(negedge adc_clk);
    check_leds("led release", 8'h5A, led_o);
    bus_write("loop set", 32'h0000_000C, 32'h1, 1);
    bus_read("loop set", 32'h0000_000C, 1, rd);
    check_word("loop set", 32'h1, rd);
    bus_write("loop clear", 32'h0000_000C, 32'h0, 1);
    bus_read("loop clear", 32'h0000_000C, 1, rd);
    check_word("loop clear", 32'h0, rd);
    bus_read("unknown offset", 32'h0000_0004, 1, rd);
    check_word("unknown offset", 32'h0, rd);
    bus_write("unused write", 32'h0050_0010, 32'hDEAD_BEEF, 0);
    bus_read("unused read", 32'h0050_0010, 0, rd);  // same-cycle ack
    check_word("unused read", 32'h0, rd);
  endtask

  task automatic loopback_path();
    logic signed [ADC_W-1:0] aa, pa, ab, pb;
    bus_write("loop on", 32'h0000_000C, 32'h1, 1);
    for (int n = 0; n < 16; n++) begin
      @(negedge adc_clk);
      aa = ADC_W'(rand_bits(ADC_W));
      pa = ADC_W'(rand_bits(ADC_W));
      ab = ADC_W'(rand_bits(ADC_W));
      pb = ADC_W'(rand_bits(ADC_W));
      asg_a_i     = aa;
      pid_a_i     = pa;
      asg_b_i     = ab;
      pid_b_i     = pb;
      adc_dat_a_i = ADC_W'(rand_bits(ADC_W));  // pins must not matter
      adc_dat_b_i = ADC_W'(rand_bits(ADC_W));
      @(negedge adc_clk);
      check_sample("loopback a", ADC_W'(clamp_sum(aa, pa)), adc_a_o);
      check_sample("loopback b", ADC_W'(clamp_sum(ab, pb)), adc_b_o);
    end
    bus_write("loop off", 32'h0000_000C, 32'h0, 1);
  endtask

  // --------------------
  initial begin
    lfsr_q       = 32'd98400;
    adc_clk      = 1'b0;
    rst_i        = 1'b1;
    adc_dat_a_i  = 14'h1FFF;
    adc_dat_b_i  = 14'h1FFF;
    asg_a_i      = '0;
    asg_b_i      = '0;
    pid_a_i      = '0;
    pid_b_i      = '0;
    rb_active_i  = 1'b0;
    rb_a_i       = '0;
    rb_b_i       = '0;
    rb_leds_en_i = 1'b0;
    rb_leds_i    = '0;
    sys_addr_i   = '0;
    sys_wdata_i  = '0;
    sys_wen_i    = 1'b0;
    sys_ren_i    = 1'b0;
    repeat (10) @(negedge adc_clk);
    if (dac_rst_o !== 1'b1) begin
      $display("dac reset low while reset is held");
      abort_run();
    end
    rst_i = 1'b0;
    @(negedge adc_clk);
    reset_state();
    adc_conversion();
    mix_saturation();
    override_select();
    register_access();
    loopback_path();
    $display("Test passed");
    $finish;
  end

endmodule

//--- list.f
sp_pkg.sv
sys_bus_if.sv
adc_front.sv
dac_mix.sv
dac_front.sv
sys_bus_decode.sv
hk_regs.sv
analog_top.sv
tb_analog_top.sv

//--- run.sh
#!/usr/bin/env bash
# build the analog path testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_analog_top -f list.f -o tb_sim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1

grep -qx "Test passed" sim.log && echo "simulation ok" \
  || { echo "simulation failed, see sim.log"; exit 1; }
